/* ipu_pkg.sv */
// Shared widths and payload types; opcode encodings 23 to 31 are illegal and never get a response
`default_nettype none

package ipu_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 5;   // 32 ids in flight at most
  localparam int unsigned ImmWidth  = 5;
  localparam int unsigned OpWidth   = 5;

  localparam int unsigned DivCountWidth = $clog2(DataWidth);  // One step per quotient bit

  // Units feeding the response merger
  localparam int unsigned NumUnits     = 3;
  localparam int unsigned UnitIdxWidth = $clog2(NumUnits);
  localparam int unsigned UnitMul      = 0;
  localparam int unsigned UnitDiv      = 1;
  localparam int unsigned UnitDsp      = 2;

  // ------------------------------
  // Opcodes
  // ------------------------------
  typedef enum logic [OpWidth-1:0] {
    MUL      = 5'd0,
    MULH     = 5'd1,
    MULHSU   = 5'd2,
    MULHU    = 5'd3,
    DIV      = 5'd4,
    DIVU     = 5'd5,
    REM      = 5'd6,
    REMU     = 5'd7,
    P_ABS    = 5'd8,
    P_SLET   = 5'd9,
    P_SLETU  = 5'd10,
    P_MIN    = 5'd11,
    P_MINU   = 5'd12,
    P_MAX    = 5'd13,
    P_MAXU   = 5'd14,
    P_EXTHS  = 5'd15,
    P_EXTHZ  = 5'd16,
    P_EXTBS  = 5'd17,
    P_EXTBZ  = 5'd18,
    P_CLIP   = 5'd19,  // Bounds from imm
    P_CLIPU  = 5'd20,
    P_CLIPR  = 5'd21,  // Bounds from arg_b
    P_CLIPUR = 5'd22
  } ipu_op_e;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  typedef struct packed {
    ipu_op_e              op;
    logic [ImmWidth-1:0]  imm;
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] arg_a;
    logic [DataWidth-1:0] arg_b;
  } ipu_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] result;
    logic [IdWidth-1:0]   id;
  } ipu_rsp_t;

endpackage

`default_nettype wire

/* ipu_multiplier.sv */
// Two stage multiplier with results two cycles after acceptance; MUL returns the low word and MULH* the high word
`timescale 1ns/1ps
`default_nettype none

module ipu_multiplier (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ipu_pkg::ipu_req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output ipu_pkg::ipu_rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  typedef struct packed {
    ipu_pkg::ipu_op_e                 op;
    logic [ipu_pkg::IdWidth-1:0]      id;
    logic [ipu_pkg::DataWidth:0]      a;   // Extended by one sign bit
    logic [ipu_pkg::DataWidth:0]      b;
  } mul_s1_t;

  typedef struct packed {
    logic                             hi;
    logic [ipu_pkg::IdWidth-1:0]      id;
    logic [2*ipu_pkg::DataWidth-1:0]  prod;
  } mul_s2_t;

  logic    s1_valid_q, s2_valid_q;
  logic    s1_ready, s2_ready;
  logic    sign_a, sign_b;
  mul_s1_t s1_d, s1_q;
  mul_s2_t s2_d, s2_q;
  logic signed [2*ipu_pkg::DataWidth+1:0] prod_full;

  // A stage moves when the next one is empty or draining
  assign s2_ready   = ~s2_valid_q | out_ready_i;
  assign s1_ready   = ~s1_valid_q | s2_ready;
  assign in_ready_o = s1_ready;

  // Operand signedness per opcode
  always_comb begin
    sign_a = 1'b0;
    sign_b = 1'b0;
    case (req_i.op)
      ipu_pkg::MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      ipu_pkg::MULHSU: sign_a = 1'b1;
      default: ;  // MUL low word is sign agnostic
    endcase
  end

  assign s1_d.op = req_i.op;
  assign s1_d.id = req_i.id;
  assign s1_d.a  = {sign_a & req_i.arg_a[ipu_pkg::DataWidth-1], req_i.arg_a};
  assign s1_d.b  = {sign_b & req_i.arg_b[ipu_pkg::DataWidth-1], req_i.arg_b};

  // 33x33 signed product covers all four variants
  assign prod_full = $signed(s1_q.a) * $signed(s1_q.b);
  assign s2_d.hi   = (s1_q.op != ipu_pkg::MUL);
  assign s2_d.id   = s1_q.id;
  assign s2_d.prod = prod_full[2*ipu_pkg::DataWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) s1_valid_q <= in_valid_i;
      if (s2_ready) s2_valid_q <= s1_valid_q;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (in_valid_i && s1_ready) s1_q <= s1_d;
    if (s1_valid_q && s2_ready) s2_q <= s2_d;
  end

  assign out_valid_o  = s2_valid_q;
  assign rsp_o.id     = s2_q.id;
  assign rsp_o.result = s2_q.hi ? s2_q.prod[2*ipu_pkg::DataWidth-1:ipu_pkg::DataWidth]
                                : s2_q.prod[ipu_pkg::DataWidth-1:0];

endmodule

`default_nettype wire

/* ipu_serial_divider.sv */
// Restoring divider taking one request at a time with about 34 cycles latency and RISC-V results for zero divisors
`timescale 1ns/1ps
`default_nettype none

module ipu_serial_divider (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ipu_pkg::ipu_req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output ipu_pkg::ipu_rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    DONE
  } div_state_e;

  div_state_e state_q;
  logic [ipu_pkg::DivCountWidth-1:0] count_q;

  logic [ipu_pkg::DataWidth-1:0] quo_q, rem_q, divisor_q;
  logic [ipu_pkg::IdWidth-1:0]   id_q;
  logic is_rem_q, neg_quo_q, neg_rem_q, div_zero_q;

  logic                          op_signed, op_rem;
  logic                          a_neg, b_neg;
  logic [ipu_pkg::DataWidth-1:0] abs_a, abs_b;
  logic [ipu_pkg::DataWidth:0]   partial, diff;
  logic                          fits;
  logic [ipu_pkg::DataWidth-1:0] quo_fix, rem_fix;

  // ------------------------------
  // Operand capture
  // ------------------------------
  assign op_signed = (req_i.op == ipu_pkg::DIV) || (req_i.op == ipu_pkg::REM);
  assign op_rem    = (req_i.op == ipu_pkg::REM) || (req_i.op == ipu_pkg::REMU);
  assign a_neg     = op_signed & req_i.arg_a[ipu_pkg::DataWidth-1];
  assign b_neg     = op_signed & req_i.arg_b[ipu_pkg::DataWidth-1];
  assign abs_a     = a_neg ? -req_i.arg_a : req_i.arg_a;
  assign abs_b     = b_neg ? -req_i.arg_b : req_i.arg_b;

  // ------------------------------
  // Shift and subtract step
  // ------------------------------
  assign partial = {rem_q, quo_q[ipu_pkg::DataWidth-1]};
  assign diff    = partial - {1'b0, divisor_q};
  assign fits    = (partial >= {1'b0, divisor_q});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (in_valid_i) begin
            state_q <= DIVIDE;
            count_q <= '0;
          end
        end
        DIVIDE: begin
          count_q <= count_q + 1'b1;
          if (count_q == '1) state_q <= DONE;  // Last quotient bit
        end
        DONE: begin
          if (out_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Quotient register starts as the dividend and fills from the right
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && in_valid_i) begin
      quo_q      <= abs_a;
      rem_q      <= '0;
      divisor_q  <= abs_b;
      id_q       <= req_i.id;
      is_rem_q   <= op_rem;
      neg_quo_q  <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;  // Remainder takes the dividend sign
      div_zero_q <= (req_i.arg_b == '0);
    end else if (state_q == DIVIDE) begin
      quo_q <= {quo_q[ipu_pkg::DataWidth-2:0], fits};
      rem_q <= fits ? diff[ipu_pkg::DataWidth-1:0] : partial[ipu_pkg::DataWidth-1:0];
    end
  end

  // ------------------------------
  // Sign fix and corner cases
  // ------------------------------
  // Overflow needs no special case since |MIN| / 1 keeps the MIN bit pattern
  assign quo_fix = div_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;  // Zero divisor leaves the dividend here

  assign in_ready_o   = (state_q == IDLE);
  assign out_valid_o  = (state_q == DONE);
  assign rsp_o.id     = id_q;
  assign rsp_o.result = is_rem_q ? rem_fix : quo_fix;

endmodule

`default_nettype wire

/* ipu_dsp_unit.sv */
// Combinational Xpulpimg operations; clipr and clipur expect a non-negative bound in arg_b
`timescale 1ns/1ps
`default_nettype none

module ipu_dsp_unit (
  input  ipu_pkg::ipu_req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output ipu_pkg::ipu_rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  // No state so handshake passes straight through
  assign out_valid_o = in_valid_i;
  assign in_ready_o  = out_ready_i;
  assign rsp_o.id    = req_i.id;

  logic                          cmp_signed;
  logic [ipu_pkg::DataWidth-1:0] cmp_a, cmp_b;
  logic                          cmp_le;

  logic [ipu_pkg::DataWidth:0]   clip_mask;
  logic [ipu_pkg::DataWidth-1:0] imm_lo, imm_hi;
  logic [ipu_pkg::DataWidth-1:0] clip_lo, clip_hi;
  logic                          clip_unsigned, clip_imm, clip_below;
  logic                          a_msb;

  assign a_msb = req_i.arg_a[ipu_pkg::DataWidth-1];

  // ------------------------------
  // Shared comparator
  // ------------------------------
  assign cmp_le = $signed({cmp_signed & cmp_a[ipu_pkg::DataWidth-1], cmp_a})
               <= $signed({cmp_signed & cmp_b[ipu_pkg::DataWidth-1], cmp_b});

  // ------------------------------
  // Clip bounds
  // ------------------------------
  assign clip_mask     = {(ipu_pkg::DataWidth+1){1'b1}} << req_i.imm;
  assign imm_lo        = clip_mask[ipu_pkg::DataWidth:1];  // -2^(imm-1)
  assign imm_hi        = ~imm_lo;                          // 2^(imm-1)-1
  assign clip_unsigned = (req_i.op == ipu_pkg::P_CLIPU) || (req_i.op == ipu_pkg::P_CLIPUR);
  assign clip_imm      = (req_i.op == ipu_pkg::P_CLIP) || (req_i.op == ipu_pkg::P_CLIPU);
  assign clip_hi       = clip_imm ? imm_hi : req_i.arg_b;
  assign clip_lo       = clip_unsigned ? '0 : (clip_imm ? imm_lo : ~req_i.arg_b);

  // Negative input tested against the lower bound, else against the upper
  assign clip_below = a_msb | clip_hi[ipu_pkg::DataWidth-1];

  // Comparator operands per opcode
  always_comb begin
    cmp_signed = 1'b1;
    cmp_a      = req_i.arg_a;
    cmp_b      = req_i.arg_b;
    case (req_i.op)
      ipu_pkg::P_ABS: cmp_b = '0;
      ipu_pkg::P_SLETU,
      ipu_pkg::P_MINU,
      ipu_pkg::P_MAXU: cmp_signed = 1'b0;
      ipu_pkg::P_CLIP,
      ipu_pkg::P_CLIPU,
      ipu_pkg::P_CLIPR,
      ipu_pkg::P_CLIPUR: cmp_b = clip_below ? clip_lo : clip_hi;
      default: ;
    endcase
  end

  // ------------------------------
  // Result select
  // ------------------------------
  always_comb begin
    rsp_o.result = '0;
    case (req_i.op)
      ipu_pkg::P_ABS: rsp_o.result = cmp_le ? -req_i.arg_a : req_i.arg_a;
      ipu_pkg::P_SLET,
      ipu_pkg::P_SLETU: rsp_o.result = {{(ipu_pkg::DataWidth-1){1'b0}}, cmp_le};
      ipu_pkg::P_MIN,
      ipu_pkg::P_MINU: rsp_o.result = cmp_le ? req_i.arg_a : req_i.arg_b;
      ipu_pkg::P_MAX,
      ipu_pkg::P_MAXU: rsp_o.result = cmp_le ? req_i.arg_b : req_i.arg_a;
      ipu_pkg::P_EXTHS: rsp_o.result = {{(ipu_pkg::DataWidth/2){req_i.arg_a[15]}},
                                        req_i.arg_a[15:0]};
      ipu_pkg::P_EXTHZ: rsp_o.result = {{(ipu_pkg::DataWidth/2){1'b0}}, req_i.arg_a[15:0]};
      ipu_pkg::P_EXTBS: rsp_o.result = {{(ipu_pkg::DataWidth-8){req_i.arg_a[7]}},
                                        req_i.arg_a[7:0]};
      ipu_pkg::P_EXTBZ: rsp_o.result = {{(ipu_pkg::DataWidth-8){1'b0}}, req_i.arg_a[7:0]};
      ipu_pkg::P_CLIP,
      ipu_pkg::P_CLIPU,
      ipu_pkg::P_CLIPR,
      ipu_pkg::P_CLIPUR: begin
        if (cmp_le) begin
          rsp_o.result = clip_below ? clip_lo : req_i.arg_a;
        end else begin
          rsp_o.result = a_msb ? req_i.arg_a : clip_hi;  // Negative a above the lower bound
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* ipu_result_arbiter.sv */
// Combinational round robin merge of the unit responses; the pointer moves past the winner after each transfer
`timescale 1ns/1ps
`default_nettype none

module ipu_result_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  ipu_pkg::ipu_rsp_t [ipu_pkg::NumUnits-1:0] rsp_i,
  input  logic [ipu_pkg::NumUnits-1:0]              valid_i,
  output logic [ipu_pkg::NumUnits-1:0]              ready_o,
  output ipu_pkg::ipu_rsp_t                         rsp_o,
  output logic                                      valid_o,
  input  logic                                      ready_i
);

  logic [ipu_pkg::UnitIdxWidth-1:0] ptr_q;
  logic [ipu_pkg::UnitIdxWidth-1:0] grant;
  logic                             found;

  // First valid input at or after the pointer
  always_comb begin
    int unsigned cand;
    grant = ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < ipu_pkg::NumUnits; k++) begin
      cand = ptr_q + k;
      if (cand >= ipu_pkg::NumUnits) cand = cand - ipu_pkg::NumUnits;  // Wrap
      if (!found && valid_i[cand]) begin
        grant = cand[ipu_pkg::UnitIdxWidth-1:0];
        found = 1'b1;
      end
    end
  end

  assign valid_o = found;
  assign rsp_o   = rsp_i[grant];

  always_comb begin
    ready_o        = '0;
    ready_o[grant] = ready_i & found;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (valid_o && ready_i) begin
      ptr_q <= (grant == ipu_pkg::NumUnits - 1) ? '0 : grant + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* ipu_top.sv */
// Integer unit top; responses may return out of order and illegal opcodes are accepted without a response
`timescale 1ns/1ps
`default_nettype none

module ipu_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ipu_pkg::ipu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output ipu_pkg::ipu_rsp_t rsp_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i
);

  logic [ipu_pkg::NumUnits-1:0]              unit_in_valid, unit_in_ready;
  logic [ipu_pkg::NumUnits-1:0]              unit_out_valid, unit_out_ready;
  ipu_pkg::ipu_rsp_t [ipu_pkg::NumUnits-1:0] unit_rsp;

  // ------------------------------
  // Dispatch
  // ------------------------------
  always_comb begin
    unit_in_valid = '0;
    req_ready_o   = 1'b1;
    case (req_i.op)
      ipu_pkg::MUL, ipu_pkg::MULH, ipu_pkg::MULHSU, ipu_pkg::MULHU: begin
        unit_in_valid[ipu_pkg::UnitMul] = req_valid_i;
        req_ready_o = unit_in_ready[ipu_pkg::UnitMul];
      end
      ipu_pkg::DIV, ipu_pkg::DIVU, ipu_pkg::REM, ipu_pkg::REMU: begin
        unit_in_valid[ipu_pkg::UnitDiv] = req_valid_i;
        req_ready_o = unit_in_ready[ipu_pkg::UnitDiv];
      end
      ipu_pkg::P_ABS, ipu_pkg::P_SLET, ipu_pkg::P_SLETU,
      ipu_pkg::P_MIN, ipu_pkg::P_MINU, ipu_pkg::P_MAX, ipu_pkg::P_MAXU,
      ipu_pkg::P_EXTHS, ipu_pkg::P_EXTHZ, ipu_pkg::P_EXTBS, ipu_pkg::P_EXTBZ,
      ipu_pkg::P_CLIP, ipu_pkg::P_CLIPU, ipu_pkg::P_CLIPR, ipu_pkg::P_CLIPUR: begin
        unit_in_valid[ipu_pkg::UnitDsp] = req_valid_i;
        req_ready_o = unit_in_ready[ipu_pkg::UnitDsp];
      end
      default: ;  // Illegal opcode swallowed
    endcase
  end

  // ------------------------------
  // Units
  // ------------------------------
  ipu_multiplier u_mul (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (unit_in_valid[ipu_pkg::UnitMul]),
    .in_ready_o  (unit_in_ready[ipu_pkg::UnitMul]),
    .rsp_o       (unit_rsp[ipu_pkg::UnitMul]),
    .out_valid_o (unit_out_valid[ipu_pkg::UnitMul]),
    .out_ready_i (unit_out_ready[ipu_pkg::UnitMul])
  );

  ipu_serial_divider u_div (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (unit_in_valid[ipu_pkg::UnitDiv]),
    .in_ready_o  (unit_in_ready[ipu_pkg::UnitDiv]),
    .rsp_o       (unit_rsp[ipu_pkg::UnitDiv]),
    .out_valid_o (unit_out_valid[ipu_pkg::UnitDiv]),
    .out_ready_i (unit_out_ready[ipu_pkg::UnitDiv])
  );

  ipu_dsp_unit u_dsp (
    .req_i       (req_i),
    .in_valid_i  (unit_in_valid[ipu_pkg::UnitDsp]),
    .in_ready_o  (unit_in_ready[ipu_pkg::UnitDsp]),
    .rsp_o       (unit_rsp[ipu_pkg::UnitDsp]),
    .out_valid_o (unit_out_valid[ipu_pkg::UnitDsp]),
    .out_ready_i (unit_out_ready[ipu_pkg::UnitDsp])
  );

  // Response merge
  ipu_result_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rsp_i   (unit_rsp),
    .valid_i (unit_out_valid),
    .ready_o (unit_out_ready),
    .rsp_o   (rsp_o),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Free running 100 ns clock; active low reset is held for the first 16 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HalfPeriod  = 50;
  localparam int ResetCycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;  // Released just after an edge like other inputs
  end

endmodule

`default_nettype wire

/* tb_ipu.sv */
// Testbench for ipu_top; responses are matched by id so any return order is accepted
`timescale 1ns/1ps
`default_nettype none

module tb_ipu;

  localparam int NumRandom = 300;
  localparam int NumReqs   = 8 * 16 + 2 * 31 + NumRandom;
  localparam int NumIds    = 1 << ipu_pkg::IdWidth;

  logic              clk;
  logic              rst_n;
  ipu_pkg::ipu_req_t req;
  logic              req_valid;
  logic              req_ready;
  ipu_pkg::ipu_rsp_t rsp;
  logic              rsp_valid;
  logic              rsp_ready;

  integer seed       = 13;
  integer ready_seed = 13;  // Separate stream for back-pressure
  int     mismatch_cnt = 0;
  int     error_cnt    = 0;
  int     rsp_cnt      = 0;
  int     next_id      = 0;

  logic              pending   [NumIds];
  ipu_pkg::ipu_rsp_t exp_table [NumIds];
  logic [31:0]       edge_vals [4];

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ipu_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic ipu_pkg::ipu_rsp_t model_rsp(ipu_pkg::ipu_req_t r);
    ipu_pkg::ipu_rsp_t m;
    logic [31:0] a, b, qu, ru;
    longint      sa, sb, ua, ub, lo, hi, qs, rs;
    logic [63:0] p_ss, p_su, p_uu;
    logic        ovf;
    a    = r.arg_a;
    b    = r.arg_b;
    sa   = $signed(a);
    sb   = $signed(b);
    ua   = {32'd0, a};
    ub   = {32'd0, b};
    p_ss = sa * sb;
    p_su = sa * ub;
    p_uu = ua * ub;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    qs   = 0;
    rs   = 0;
    qu   = '0;
    ru   = '0;
    if (b != 32'd0) begin
      qs = sa / sb;  // Truncates toward zero
      rs = sa % sb;
      qu = a / b;
      ru = a % b;
    end
    m.id     = r.id;
    m.result = '0;
    case (r.op)
      ipu_pkg::MUL:     m.result = p_ss[31:0];
      ipu_pkg::MULH:    m.result = p_ss[63:32];
      ipu_pkg::MULHSU:  m.result = p_su[63:32];
      ipu_pkg::MULHU:   m.result = p_uu[63:32];
      ipu_pkg::DIV:     m.result = (b == 32'd0) ? 32'hffff_ffff : (ovf ? a : qs[31:0]);
      ipu_pkg::DIVU:    m.result = (b == 32'd0) ? 32'hffff_ffff : qu;
      ipu_pkg::REM:     m.result = (b == 32'd0) ? a : (ovf ? 32'd0 : rs[31:0]);
      ipu_pkg::REMU:    m.result = (b == 32'd0) ? a : ru;
      ipu_pkg::P_ABS:   m.result = (sa < 0) ? (32'd0 - a) : a;
      ipu_pkg::P_SLET:  m.result = {31'd0, sa <= sb};
      ipu_pkg::P_SLETU: m.result = {31'd0, a <= b};
      ipu_pkg::P_MIN:   m.result = (sa <= sb) ? a : b;
      ipu_pkg::P_MINU:  m.result = (a <= b) ? a : b;
      ipu_pkg::P_MAX:   m.result = (sa >= sb) ? a : b;
      ipu_pkg::P_MAXU:  m.result = (a >= b) ? a : b;
      ipu_pkg::P_EXTHS: m.result = {{16{a[15]}}, a[15:0]};
      ipu_pkg::P_EXTHZ: m.result = {16'd0, a[15:0]};
      ipu_pkg::P_EXTBS: m.result = {{24{a[7]}}, a[7:0]};
      ipu_pkg::P_EXTBZ: m.result = {24'd0, a[7:0]};
      ipu_pkg::P_CLIP, ipu_pkg::P_CLIPU, ipu_pkg::P_CLIPR, ipu_pkg::P_CLIPUR: begin
        if (r.op == ipu_pkg::P_CLIP || r.op == ipu_pkg::P_CLIPU) begin
          hi = (longint'(1) << (r.imm - 1)) - 1;
          lo = (r.op == ipu_pkg::P_CLIP) ? -hi - 1 : 0;
        end else begin
          hi = sb;  // Register bound
          lo = (r.op == ipu_pkg::P_CLIPR) ? -sb - 1 : 0;
        end
        if (sa < lo) m.result = lo[31:0];
        else if (sa > hi) m.result = hi[31:0];
        else m.result = a;
      end
      default: m.result = '0;
    endcase
    return m;
  endfunction

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;  // Most negative
      3'd3:    return 32'h7fff_ffff;
      3'd4:    return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  function automatic int find_free_id();
    int cand;
    for (int k = 0; k < NumIds; k++) begin
      cand = (next_id + k) % NumIds;
      if (!pending[cand]) return cand;
    end
    return -1;
  endfunction

  function automatic int count_pending();
    int n;
    n = 0;
    for (int k = 0; k < NumIds; k++) n += int'(pending[k]);
    return n;
  endfunction

  task automatic check_rsp(input ipu_pkg::ipu_rsp_t got, input ipu_pkg::ipu_rsp_t expected);
    if (got !== expected) begin
      mismatch_cnt++;
      $display("mismatch at %0t: rsp_o got result=%h id=%0d, expected result=%h id=%0d",
               $time, got.result, got.id, expected.result, expected.id);
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d responses, %0d mismatches, %0d other errors",
             rsp_cnt, mismatch_cnt, error_cnt);
  endtask

  // Drive one request from just after a rising edge until it is taken
  task automatic issue(input logic [4:0] op_bits, input logic [4:0] imm,
                       input logic [31:0] a, input logic [31:0] b);
    int                id;
    logic              legal;
    logic              accepted;
    ipu_pkg::ipu_req_t r;
    id = find_free_id();
    while (id < 0) begin
      @(posedge clk);
      #1;
      id = find_free_id();
    end
    next_id  = (id + 1) % NumIds;
    legal    = (op_bits <= ipu_pkg::P_CLIPUR);
    r.op     = ipu_pkg::ipu_op_e'(op_bits);
    r.imm    = imm;
    r.id     = id[ipu_pkg::IdWidth-1:0];
    r.arg_a  = a;
    r.arg_b  = b;
    req       = r;
    req_valid = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (req_ready) begin
        accepted = 1'b1;
      end else if (!legal) begin
        error_cnt++;
        $display("illegal opcode %0d with id %0d was not accepted in its first cycle at %0t",
                 op_bits, id, $time);
        accepted = 1'b1;
      end else begin
        @(posedge clk);
        #1;
      end
    end
    if (legal) begin
      exp_table[id] = model_rsp(r);
      pending[id]   = 1'b1;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // ------------------------------
  // Response side
  // ------------------------------
  initial begin
    rsp_ready = 1'b0;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      rsp_ready = ($random(ready_seed) & 3) != 0;  // Ready about 3 of 4 cycles
    end
  end

  always @(negedge clk) begin
    #10;
    if (rst_n && rsp_valid && rsp_ready) begin
      rsp_cnt++;
      if (!pending[rsp.id]) begin
        error_cnt++;
        $display("response with id %0d at %0t has no outstanding request", rsp.id, $time);
      end else begin
        check_rsp(rsp, exp_table[rsp.id]);
        pending[rsp.id] = 1'b0;
      end
    end
  end

  initial begin
    repeat (NumReqs * 40 + 200) @(posedge clk);
    $display("watchdog expired with %0d requests still outstanding", count_pending());
    print_summary();
    $display("TESTS FAILED");
    $finish;
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    logic [31:0] rnd;
    logic [4:0]  op_bits;
    logic [4:0]  imm;
    logic [31:0] a;
    logic [31:0] b;
    req       = '0;
    req_valid = 1'b0;
    for (int k = 0; k < NumIds; k++) pending[k] = 1'b0;
    edge_vals = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    @(posedge rst_n);
    @(negedge clk);
    if (rsp_valid !== 1'b0) begin
      error_cnt++;
      $display("response valid is not low after reset");
    end
    @(posedge clk);
    #1;

    // Multiply and divide ops on all edge pairs, zero divisor and overflow included
    for (int op = 0; op < 8; op++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue(op[4:0], 5'd0, edge_vals[i], edge_vals[j]);
        end
      end
    end

    for (int k = 1; k < 32; k++) begin
      issue(ipu_pkg::P_CLIP, k[4:0], pick_operand(), 32'd0);
      issue(ipu_pkg::P_CLIPU, k[4:0], pick_operand(), 32'd0);
    end

    // Mixed stream, illegal opcodes included
    for (int n = 0; n < NumRandom; n++) begin
      rnd     = $random(seed);
      op_bits = rnd[4:0];
      imm     = rnd[9:5];
      a       = pick_operand();
      b       = pick_operand();
      if (op_bits == ipu_pkg::P_CLIP || op_bits == ipu_pkg::P_CLIPU) begin
        imm = (imm == 5'd0) ? 5'd1 : imm;
      end
      if (op_bits == ipu_pkg::P_CLIPR || op_bits == ipu_pkg::P_CLIPUR) begin
        b[31] = 1'b0;  // Bound must be non-negative
      end
      if (rnd[12:10] == 3'd0) begin
        @(posedge clk);
        #1;
      end
      issue(op_bits, imm, a, b);
    end

    while (count_pending() != 0) begin
      @(posedge clk);
    end
    repeat (50) @(posedge clk);  // Catch late or stray responses
    print_summary();
    if (mismatch_cnt == 0 && error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
ipu_pkg.sv
ipu_multiplier.sv
ipu_serial_divider.sv
ipu_dsp_unit.sv
ipu_result_arbiter.sv
ipu_top.sv
tb_clock_gen.sv
tb_ipu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_ipu
FILELIST  := tb.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
